// ==== sim.f ====
src/cpu_pkg.sv
src/exec_if.sv
src/issue_ctrl.sv
src/addsub_unit.sv
src/mult_unit.sv
src/reg_writeback.sv
src/cpu_core.sv
sim/cpu_core_properties.sv
sim/tb_cpu_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

# Build with assertions on, then run; a $fatal gives a failing exit status
verilator --binary --timing --assert --top-module tb_cpu_core \
    -f sim.f -o sim_cpu_core
./obj_dir/sim_cpu_core

// ==== sim/tb_cpu_core.sv ====
`default_nettype none

module tb_cpu_core
    import cpu_pkg::*;
();

    // Reset plus ~230 instructions at up to 12 cycles each, with margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int RAND_COUNT     = 200;

    logic                 clk;
    logic                 rst_n;
    logic                 inst_req;
    logic [INST_W-1:0]    inst;
    logic                 host_we;
    logic [REG_IDX_W-1:0] host_idx;
    logic [DATA_W-1:0]    host_data;
    logic                 inst_ack;
    logic [DATA_W-1:0]    result_data;
    logic [REG_IDX_W-1:0] result_rd;
    logic                 inst_err;

    // Model register file and results still waiting for their ack
    logic [DATA_W-1:0]    model_regs [REG_NUM];
    logic [DATA_W-1:0]    exp_data_q [$];
    logic [REG_IDX_W-1:0] exp_rd_q [$];
    logic                 exp_err_q [$];
    int                   issued;
    int                   checked;
    int                   cycles;

    cpu_core DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_req    (inst_req),
        .inst        (inst),
        .inst_ack    (inst_ack),
        .result_data (result_data),
        .result_rd   (result_rd),
        .inst_err    (inst_err),
        .host_we     (host_we),
        .host_idx    (host_idx),
        .host_data   (host_data)
    );

    // ########################################
    // Clock and timeout
    // ########################################
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    // ########################################
    // Reference model
    // ########################################

    // ADD/SUB wrap, SLT signed 1 or 0, MULT keeps low half of signed product
    function automatic logic [DATA_W-1:0] ref_result(input logic [INST_W-1:0] word,
                                                     output logic illegal);
        alu_op_e           op;
        int                a;
        int                b;
        logic [DATA_W-1:0] res;
        illegal = 1'b0;
        op      = ALU_ADD;
        res     = '0;
        a = int'($signed(model_regs[word[RS_LSB +: REG_IDX_W]]));
        b = int'($signed(model_regs[word[RT_LSB +: REG_IDX_W]]));
        case (word[OPC_MSB:OPC_LSB])
            OPC_ADDSUB: op = word[FUNC_BIT] ? ALU_ADD : ALU_SUB;
            OPC_MULSLT: op = word[FUNC_BIT] ? ALU_SLT : ALU_MUL;
            default:    illegal = 1'b1;
        endcase
        if (!illegal) begin
            case (op)
                ALU_ADD: res = DATA_W'(a + b);
                ALU_SUB: res = DATA_W'(a - b);
                ALU_MUL: res = DATA_W'(a * b);
                default: res = (a < b) ? DATA_W'(1) : '0;
            endcase
        end
        return res;
    endfunction

    function automatic logic [INST_W-1:0] make_inst(input logic [2:0] opc,
                                                    input logic func,
                                                    input logic [REG_IDX_W-1:0] rs,
                                                    input logic [REG_IDX_W-1:0] rt,
                                                    input logic [REG_IDX_W-1:0] rd);
        logic [INST_W-1:0] w;
        w = '0;
        w[OPC_MSB:OPC_LSB]      = opc;
        w[RS_LSB +: REG_IDX_W]  = rs;
        w[RT_LSB +: REG_IDX_W]  = rt;
        w[RD_LSB +: REG_IDX_W]  = rd;
        w[FUNC_BIT]             = func;
        return w;
    endfunction

    // ########################################
    // Compare tasks
    // ########################################
    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] expv,
                              input string what);
        if (got !== expv) begin
            $display("ERR %0t: %s got 0x%h expected 0x%h", $time, what, got, expv);
            $display("RESULT: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_idx(input logic [REG_IDX_W-1:0] got,
                             input logic [REG_IDX_W-1:0] expv, input string what);
        if (got !== expv) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, expv);
            $display("RESULT: FAIL");
            $fatal(1, "index mismatch");
        end
    endtask

    task automatic check_err(input logic got, input logic expv, input string what);
        if (got !== expv) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, expv);
            $display("RESULT: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Sampled on the falling edge, away from the driving edge
    initial begin : compare_proc
        logic ack_d;
        logic err_exp;
        ack_d = 1'b0;
        forever begin
            @(negedge clk);
            if (inst_ack && !ack_d) begin
                if (exp_err_q.size() == 0) begin
                    $display("The core acknowledged an instruction that was never sent");
                    $display("RESULT: FAIL");
                    $fatal(1, "unexpected ack");
                end
                err_exp = exp_err_q.pop_front();
                check_err(inst_err, err_exp, "inst_err");
                // Result outputs mean nothing for an illegal opcode
                if (!err_exp) begin
                    check_data(result_data, exp_data_q.pop_front(), "result_data");
                    check_idx(result_rd, exp_rd_q.pop_front(), "result_rd");
                end else begin
                    void'(exp_data_q.pop_front());
                    void'(exp_rd_q.pop_front());
                end
                checked++;
            end
            ack_d = inst_ack;
        end
    end

    // ########################################
    // Host side of the handshake
    // ########################################

    // Only called while req and ack are both low
    task automatic host_write(input logic [REG_IDX_W-1:0] idx, input logic [DATA_W-1:0] data);
        @(posedge clk);
        host_we   <= 1'b1;
        host_idx  <= idx;
        host_data <= data;
        @(posedge clk);
        host_we   <= 1'b0;
        model_regs[idx] = data;
    endtask

    // One four-phase transfer, holding req for extra cycles after the ack
    task automatic run_inst(input logic [INST_W-1:0] word, input int hold);
        logic              illegal;
        logic [DATA_W-1:0] res;
        res = ref_result(word, illegal);
        exp_data_q.push_back(res);
        exp_rd_q.push_back(word[RD_LSB +: REG_IDX_W]);
        exp_err_q.push_back(illegal);
        if (!illegal) model_regs[word[RD_LSB +: REG_IDX_W]] = res;
        issued++;
        @(posedge clk);
        inst_req <= 1'b1;
        inst     <= word;
        @(negedge clk);
        while (!inst_ack) @(negedge clk);
        repeat (hold) @(posedge clk);
        @(posedge clk);
        inst_req <= 1'b0;
        @(negedge clk);
        while (inst_ack) @(negedge clk);
    endtask

    // ########################################
    // Test sequence
    // ########################################
    initial begin : main_seq
        logic [REG_IDX_W-1:0] rs;
        logic [REG_IDX_W-1:0] last_rd;
        void'($urandom(68));
        rst_n     = 1'b0;
        inst_req  = 1'b0;
        inst      = '0;
        host_we   = 1'b0;
        host_idx  = '0;
        host_data = '0;
        issued    = 0;
        checked   = 0;
        for (int i = 0; i < REG_NUM; i++) model_regs[i] = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_err(inst_ack, 1'b0, "inst_ack after reset");
        check_err(inst_err, 1'b0, "inst_err after reset");

        // Registers out of reset all read zero
        run_inst(make_inst(OPC_ADDSUB, 1'b1, 4'd3, 4'd7, 4'd1), 0);
        run_inst(make_inst(OPC_ADDSUB, 1'b1, 4'd15, 4'd14, 4'd2), 1);

        // Wrapping add and subtract corners
        host_write(4'd1, 16'h7FFF);
        host_write(4'd2, 16'h0001);
        host_write(4'd3, 16'h8000);
        host_write(4'd4, 16'h1234);
        host_write(4'd5, 16'hFFFF);
        run_inst(make_inst(OPC_ADDSUB, 1'b1, 4'd1, 4'd2, 4'd6), 0);
        run_inst(make_inst(OPC_ADDSUB, 1'b0, 4'd3, 4'd2, 4'd7), 0);
        run_inst(make_inst(OPC_ADDSUB, 1'b0, 4'd2, 4'd5, 4'd8), 2);
        run_inst(make_inst(OPC_ADDSUB, 1'b1, 4'd5, 4'd5, 4'd9), 0);
        run_inst(make_inst(OPC_ADDSUB, 1'b0, 4'd4, 4'd4, 4'd10), 0);

        // Signed compare, both orders and equal
        run_inst(make_inst(OPC_MULSLT, 1'b1, 4'd3, 4'd1, 4'd11), 0);
        run_inst(make_inst(OPC_MULSLT, 1'b1, 4'd1, 4'd3, 4'd11), 0);
        run_inst(make_inst(OPC_MULSLT, 1'b1, 4'd4, 4'd4, 4'd11), 0);
        run_inst(make_inst(OPC_MULSLT, 1'b1, 4'd5, 4'd2, 4'd12), 1);
        run_inst(make_inst(OPC_MULSLT, 1'b1, 4'd2, 4'd5, 4'd12), 0);

        // Signed multiply, negatives and overflow
        host_write(4'd8, 16'hFFFD);
        host_write(4'd9, 16'h0007);
        host_write(4'd10, 16'h0123);
        host_write(4'd11, 16'h4567);
        run_inst(make_inst(OPC_MULSLT, 1'b0, 4'd8, 4'd9, 4'd13), 0);
        run_inst(make_inst(OPC_MULSLT, 1'b0, 4'd8, 4'd8, 4'd13), 0);
        run_inst(make_inst(OPC_MULSLT, 1'b0, 4'd10, 4'd11, 4'd14), 3);
        run_inst(make_inst(OPC_MULSLT, 1'b0, 4'd3, 4'd5, 4'd14), 0);
        run_inst(make_inst(OPC_MULSLT, 1'b0, 4'd1, 4'd1, 4'd15), 0);

        // Illegal opcodes leave r12 alone, ADD with r0 reads it back
        host_write(4'd0, 16'h0000);
        host_write(4'd12, 16'hA5A5);
        for (int k = 2; k < 8; k++) begin
            run_inst(make_inst(3'(k), 1'(k), 4'd1, 4'd2, 4'd12), 0);
            run_inst(make_inst(OPC_ADDSUB, 1'b1, 4'd12, 4'd0, 4'd13), 0);
        end

        // Random legal traffic, rs often chained to the last rd
        for (int i = 0; i < REG_NUM; i++) begin
            host_write(REG_IDX_W'(i), DATA_W'($urandom()));
        end
        last_rd = '0;
        for (int n = 0; n < RAND_COUNT; n++) begin
            rs = ($urandom_range(1, 0) == 1) ? last_rd : REG_IDX_W'($urandom_range(15, 0));
            last_rd = REG_IDX_W'($urandom_range(15, 0));
            run_inst(make_inst(3'($urandom_range(1, 0)), 1'($urandom_range(1, 0)), rs,
                               REG_IDX_W'($urandom_range(15, 0)), last_rd),
                     $urandom_range(3, 0));
        end

        repeat (2) @(negedge clk);
        if (checked == issued && exp_err_q.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Only %0d of %0d instructions were acknowledged", checked, issued);
            $display("RESULT: FAIL");
            $fatal(1, "missing acknowledges");
        end
    end

endmodule

`default_nettype wire

// ==== sim/cpu_core_properties.sv ====
`default_nettype none

module cpu_core_properties (
    input logic clk,
    input logic rst_n,
    input logic inst_req,
    input logic inst_ack,
    input logic issue,
    input logic sum_valid,
    input logic prod_valid
);

    // ########################################
    // Four-phase handshake
    // ########################################

    // Ack only answers a pending request
    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(inst_ack) |-> inst_req)
        else $error("inst_ack rose while inst_req was low");

    // Ack drops only once the host has let go
    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(inst_ack) |-> $past(!inst_req))
        else $error("inst_ack fell before inst_req went low");

    // ########################################
    // Execution pipeline
    // ########################################
    a_issue_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        issue |=> !issue)
        else $error("issue held for two cycles");

    // One unit per issue, so results never collide at writeback
    a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        !(sum_valid && prod_valid))
        else $error("sum_valid and prod_valid high together");

endmodule

bind cpu_core cpu_core_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_req   (inst_req),
    .inst_ack   (inst_ack),
    .issue      (ex_bus.issue),
    .sum_valid  (sum_valid),
    .prod_valid (prod_valid)
);

`default_nettype wire

// ==== src/cpu_core.sv ====
`default_nettype none

module cpu_core
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    // Instruction handshake
    input  logic                 inst_req,
    input  logic [INST_W-1:0]    inst,
    output logic                 inst_ack,
    output logic [DATA_W-1:0]    result_data,
    output logic [REG_IDX_W-1:0] result_rd,
    output logic                 inst_err,
    // Host preload port
    input  logic                 host_we,
    input  logic [REG_IDX_W-1:0] host_idx,
    input  logic [DATA_W-1:0]    host_data
);

    // ########################################
    // Internal nets
    // ########################################
    logic                 sum_valid;
    logic [DATA_W-1:0]    sum_data;
    logic                 prod_valid;
    logic [DATA_W-1:0]    prod_data;
    logic [REG_IDX_W-1:0] rs_idx;
    logic [REG_IDX_W-1:0] rt_idx;
    logic [DATA_W-1:0]    rs_data;
    logic [DATA_W-1:0]    rt_data;
    logic                 done;

    exec_if ex_bus ();

    issue_ctrl u_issue_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst_req (inst_req),
        .inst     (inst),
        .done     (done),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .ex       (ex_bus.ctrl),
        .inst_ack (inst_ack),
        .inst_err (inst_err)
    );

    // Execution units side by side
    addsub_unit u_addsub (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex        (ex_bus.unit),
        .sum_valid (sum_valid),
        .sum_data  (sum_data)
    );

    mult_unit u_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex         (ex_bus.unit),
        .prod_valid (prod_valid),
        .prod_data  (prod_data)
    );

    reg_writeback u_reg_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb          (ex_bus.wb),
        .sum_valid   (sum_valid),
        .prod_valid  (prod_valid),
        .sum_data    (sum_data),
        .prod_data   (prod_data),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .host_we     (host_we),
        .host_idx    (host_idx),
        .host_data   (host_data),
        .done        (done),
        .result_data (result_data),
        .result_rd   (result_rd)
    );

endmodule

`default_nettype wire

// ==== src/reg_writeback.sv ====
`default_nettype none

module reg_writeback
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    exec_if.wb                   wb,
    input  logic                 sum_valid,
    input  logic                 prod_valid,
    input  logic [DATA_W-1:0]    sum_data,
    input  logic [DATA_W-1:0]    prod_data,
    input  logic [REG_IDX_W-1:0] rs_idx,
    input  logic [REG_IDX_W-1:0] rt_idx,
    output logic [DATA_W-1:0]    rs_data,
    output logic [DATA_W-1:0]    rt_data,
    input  logic                 host_we,
    input  logic [REG_IDX_W-1:0] host_idx,
    input  logic [DATA_W-1:0]    host_data,
    output logic                 done,
    output logic [DATA_W-1:0]    result_data,
    output logic [REG_IDX_W-1:0] result_rd
);

    logic [DATA_W-1:0]    regs [REG_NUM];
    logic [REG_IDX_W-1:0] rd_d1;
    logic [REG_IDX_W-1:0] rd_d2;
    logic                 wr_en;
    logic [DATA_W-1:0]    wr_data;
    logic [REG_IDX_W-1:0] wr_idx;

    // ########################################
    // Destination tracking
    // ########################################

    // d1 lines up with addsub, d2 with the multiplier
    always_ff @(posedge clk) begin
        rd_d1 <= wb.rd;
        rd_d2 <= rd_d1;
    end

    // At most one unit answers, product checked first anyway
    assign wr_en   = sum_valid || prod_valid;
    assign wr_data = prod_valid ? prod_data : sum_data;
    assign wr_idx  = prod_valid ? rd_d2 : rd_d1;

    // ########################################
    // Register file
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (host_we) begin
            regs[host_idx] <= host_data;
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Asynchronous read ports for operand fetch
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    // Completion pulse to control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= wr_en;
        end
    end

    // Result copy stays put until the next write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            result_data <= wr_data;
            result_rd   <= wr_idx;
        end
    end

endmodule

`default_nettype wire

// ==== src/mult_unit.sv ====
`default_nettype none

module mult_unit
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    exec_if.unit              ex,
    output logic              prod_valid,
    output logic [DATA_W-1:0] prod_data
);

    logic                       mul_v1;
    logic signed [DATA_W-1:0]   a_q;
    logic signed [DATA_W-1:0]   b_q;
    logic signed [2*DATA_W-1:0] full_prod;

    // ########################################
    // Valid bits, one per stage
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_v1     <= 1'b0;
            prod_valid <= 1'b0;
        end else begin
            mul_v1     <= ex.issue && (ex.op == ALU_MUL);
            prod_valid <= mul_v1;
        end
    end

    // Stage one holds the operands
    always_ff @(posedge clk) begin
        if (ex.issue && (ex.op == ALU_MUL)) begin
            a_q <= ex.a;
            b_q <= ex.b;
        end
    end

    // Stage two keeps the low half of the signed product
    assign full_prod = a_q * b_q;

    always_ff @(posedge clk) begin
        if (mul_v1) prod_data <= full_prod[DATA_W-1:0];
    end

endmodule

`default_nettype wire

// ==== src/addsub_unit.sv ====
`default_nettype none

module addsub_unit
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    exec_if.unit              ex,
    output logic              sum_valid,
    output logic [DATA_W-1:0] sum_data
);

    // Multiply belongs to the other unit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= ex.issue && (ex.op != ALU_MUL);
        end
    end

    // Wrapping arithmetic, SLT yields 1 or 0
    always_ff @(posedge clk) begin
        if (ex.issue) begin
            case (ex.op)
                ALU_ADD: sum_data <= ex.a + ex.b;
                ALU_SUB: sum_data <= ex.a - ex.b;
                ALU_SLT: sum_data <= DATA_W'($signed(ex.a) < $signed(ex.b));
                default: sum_data <= sum_data;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/issue_ctrl.sv ====
`default_nettype none

module issue_ctrl
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_req,
    input  logic [INST_W-1:0]    inst,
    input  logic                 done,
    output logic [REG_IDX_W-1:0] rs_idx,
    output logic [REG_IDX_W-1:0] rt_idx,
    input  logic [DATA_W-1:0]    rs_data,
    input  logic [DATA_W-1:0]    rt_data,
    exec_if.ctrl                 ex,
    output logic                 inst_ack,
    output logic                 inst_err
);

    ctrl_state_e       state;
    logic [INST_W-1:0] inst_q;
    opcode_e           opc;
    logic              legal;
    alu_op_e           dec_op;

    // ########################################
    // Instruction latch and decode
    // ########################################

    // Captured once at acceptance, held until the next one
    always_ff @(posedge clk) begin
        if (state == S_IDLE && inst_req) begin
            inst_q <= inst;
        end
    end

    assign opc    = opcode_e'(inst_q[OPC_MSB:OPC_LSB]);
    assign legal  = (opc == OPC_ADDSUB) || (opc == OPC_MULSLT);
    assign rs_idx = inst_q[RS_LSB +: REG_IDX_W];
    assign rt_idx = inst_q[RT_LSB +: REG_IDX_W];

    // func picks within each group, add/sub and mult/slt
    always_comb begin
        case (opc)
            OPC_ADDSUB: dec_op = inst_q[FUNC_BIT] ? ALU_ADD : ALU_SUB;
            OPC_MULSLT: dec_op = inst_q[FUNC_BIT] ? ALU_SLT : ALU_MUL;
            default:    dec_op = ALU_ADD;
        endcase
    end

    // Issue strobe lives for the whole S_ISSUE cycle only
    assign ex.issue = (state == S_ISSUE) && legal;
    assign ex.op    = dec_op;
    assign ex.a     = rs_data;
    assign ex.b     = rt_data;
    assign ex.rd    = inst_q[RD_LSB +: REG_IDX_W];

    // ########################################
    // Control FSM and four-phase ack
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            inst_ack <= 1'b0;
            inst_err <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (inst_req) state <= S_ISSUE;
                end
                // Illegal opcode bypasses the units entirely
                S_ISSUE: begin
                    inst_err <= !legal;
                    state    <= legal ? S_WAIT : S_ACK;
                end
                S_WAIT: begin
                    if (done) state <= S_ACK;
                end
                // Raise ack, then hold it until the host lets go of req
                S_ACK: begin
                    if (!inst_ack) begin
                        inst_ack <= 1'b1;
                    end else if (!inst_req) begin
                        inst_ack <= 1'b0;
                        inst_err <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/exec_if.sv ====
`default_nettype none

// One issued operation, from control out to the execution units
interface exec_if
    import cpu_pkg::*;
();

    // Single-cycle strobe
    logic                 issue;
    alu_op_e              op;
    // Operand values straight from the register file read ports
    logic [DATA_W-1:0]    a;
    logic [DATA_W-1:0]    b;
    // Destination register
    logic [REG_IDX_W-1:0] rd;

    modport ctrl (
        output issue,
        output op,
        output a,
        output b,
        output rd
    );

    // Units only need the operation and operands
    modport unit (
        input issue,
        input op,
        input a,
        input b
    );

    // Writeback tracks the destination alongside each unit
    modport wb (
        input rd
    );

endinterface

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // ########################################
    // Widths
    // ########################################
    localparam int DATA_W    = 16;
    localparam int INST_W    = 16;
    localparam int REG_NUM   = 16;
    localparam int REG_IDX_W = 4;

    // Instruction layout  opc[15:13] rs[12:9] rt[8:5] rd[4:1] func[0]
    localparam int OPC_MSB  = 15;
    localparam int OPC_LSB  = 13;
    localparam int RS_LSB   = 9;
    localparam int RT_LSB   = 5;
    localparam int RD_LSB   = 1;
    localparam int FUNC_BIT = 0;

    // ########################################
    // Encodings
    // ########################################

    // Any opcode outside the two R-type groups is illegal
    typedef enum logic [2:0] {
        OPC_ADDSUB = 3'd0,
        OPC_MULSLT = 3'd1
    } opcode_e;

    // Operation select carried to the execution units
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_MUL = 2'd2,
        ALU_SLT = 2'd3
    } alu_op_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_ACK
    } ctrl_state_e;

endpackage

`default_nettype wire
